// File: list.f
+incdir+source
source/hci_csr_pkg.sv
source/hci_queue_pkg.sv
source/hci_csr_regs.sv
source/hci_cmd_packer.sv
source/hci_queue.sv
source/hci_top.sv
testbench/tb_hci.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it, log goes to sim.log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hci -f list.f -Mdir "$BUILD_DIR" -o tb_hci
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_hci" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation passed"
exit 0

// File: source/hci_cfg.svh
/* Build-time macros for the HCI PIO queue core
   CSR map, bus and field widths, queue depth and RESET_CONTROL bit positions */
`ifndef HCI_CFG_SVH
`define HCI_CFG_SVH

`define HCI_CSR_AW 12
`define HCI_CSR_DW 32
`define HCI_QUEUE_DEPTH 8
`define HCI_THLD_W 8

// CSR offsets
`define HCI_ADDR_RESET_CONTROL 12'h010
`define HCI_ADDR_COMMAND_PORT 12'h0C0
`define HCI_ADDR_RESPONSE_PORT 12'h0C4
`define HCI_ADDR_QUEUE_THLD_CTRL 12'h0D0
`define HCI_ADDR_QUEUE_STATUS 12'h0D8

`define HCI_CMD_RST_BIT 1
`define HCI_RESP_RST_BIT 2

// QUEUE_THLD_CTRL fields, QUEUE_STATUS reuses the same layout for counts
`define HCI_CMD_THLD_LSB 0
`define HCI_RESP_THLD_LSB 8

`endif

// File: source/hci_cmd_packer.sv
/* Command assembly: pairs COMMAND_PORT DWORDs into a descriptor
   and holds it until the command queue takes it */
module hci_cmd_packer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      dword_valid_i,
  input  hci_csr_pkg::csr_data_t    dword_data_i,
  output logic                      dword_done_o,
  output logic                      push_valid_o,
  output hci_queue_pkg::cmd_desc_t  push_data_o,
  input  logic                      push_ready_i,
  input  logic                      flush_i
);
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;

  logic      have_lo_q;
  logic      push_valid_q;
  csr_data_t lo_q;
  cmd_desc_t desc_q;
  logic      slot_free;

  // Output slot empty now or emptied this cycle
  assign slot_free    = !push_valid_q || push_ready_i;
  assign dword_done_o = dword_valid_i && slot_free && !flush_i;
  assign push_valid_o = push_valid_q;
  assign push_data_o  = desc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      have_lo_q    <= 1'b0;
      push_valid_q <= 1'b0;
    end else if (flush_i) begin
      have_lo_q    <= 1'b0; // Drop partial and held command
      push_valid_q <= 1'b0;
    end else begin
      if (push_valid_q && push_ready_i) push_valid_q <= 1'b0;
      if (dword_done_o) begin
        have_lo_q <= !have_lo_q;
        if (have_lo_q) push_valid_q <= 1'b1; // Second DWORD completes it
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dword_done_o) begin
      if (!have_lo_q) begin
        lo_q <= dword_data_i;
      end else begin
        desc_q.hi <= dword_data_i;
        desc_q.lo <= lo_q;
      end
    end
  end

  // Descriptor held steady while the queue stalls
  a_push_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_valid_o && !push_ready_i && !flush_i |=> push_valid_o && $stable(push_data_o));

endmodule

// File: source/hci_csr_pkg.sv
/* CPU-side access types: CSR address, data word, threshold field
   and the register select decoded from the address */
`include "hci_cfg.svh"

package hci_csr_pkg;

  typedef logic [`HCI_CSR_AW-1:0] csr_addr_t;
  typedef logic [`HCI_CSR_DW-1:0] csr_data_t;

  // One queue threshold field
  typedef logic [`HCI_THLD_W-1:0] thld_t;

  // Register targeted by the pending access
  typedef enum logic [2:0] {
    SEL_NONE,       // Unmapped, reads 0
    SEL_CMD_PORT,
    SEL_RESP_PORT,
    SEL_THLD,
    SEL_RESET,
    SEL_STATUS
  } reg_sel_t;

endpackage

// File: source/hci_csr_regs.sv
/* CSR block: request decode and pending access, threshold and reset-control registers,
   status readback, COMMAND_PORT forwarding and RESPONSE_PORT reads */
`include "hci_cfg.svh"

module hci_csr_regs (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cpu_req_i,
  input  logic                       cpu_wr_i,
  input  hci_csr_pkg::csr_addr_t     cpu_addr_i,
  input  hci_csr_pkg::csr_data_t     cpu_wdata_i,
  output logic                       cpu_ack_o,
  output hci_csr_pkg::csr_data_t     cpu_rdata_o,
  output logic                       dword_valid_o,
  output hci_csr_pkg::csr_data_t     dword_data_o,
  input  logic                       dword_done_i,
  input  logic                       resp_valid_i,
  input  hci_queue_pkg::resp_desc_t  resp_data_i,
  output logic                       resp_pop_o,
  output hci_csr_pkg::thld_t         cmd_thld_o,
  output hci_csr_pkg::thld_t         resp_thld_o,
  output logic                       cmd_flush_o,
  output logic                       resp_flush_o,
  input  hci_queue_pkg::queue_cnt_t  cmd_cnt_i,
  input  hci_queue_pkg::queue_cnt_t  resp_cnt_i
);
  import hci_csr_pkg::*;

  reg_sel_t  req_sel;
  reg_sel_t  sel_q;
  logic      pending_q;
  logic      wr_q;
  csr_data_t wdata_q;
  logic      access_done;
  logic      wr_ack;
  thld_t     cmd_thld_q;
  thld_t     resp_thld_q;
  logic      cmd_rst_q;
  logic      resp_rst_q;

  // Keep a programmed threshold within 1..depth
  function automatic thld_t clamp_thld(input thld_t val);
    if (val == '0) return thld_t'(1);
    if (val > thld_t'(`HCI_QUEUE_DEPTH)) return thld_t'(`HCI_QUEUE_DEPTH);
    return val;
  endfunction

  always_comb begin
    unique case (cpu_addr_i)
      `HCI_ADDR_COMMAND_PORT:    req_sel = SEL_CMD_PORT;
      `HCI_ADDR_RESPONSE_PORT:   req_sel = SEL_RESP_PORT;
      `HCI_ADDR_QUEUE_THLD_CTRL: req_sel = SEL_THLD;
      `HCI_ADDR_RESET_CONTROL:   req_sel = SEL_RESET;
      `HCI_ADDR_QUEUE_STATUS:    req_sel = SEL_STATUS;
      default:                   req_sel = SEL_NONE;
    endcase
  end

  // One access in flight, opened by the request pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      wr_q      <= 1'b0;
      sel_q     <= SEL_NONE;
    end else if (cpu_req_i) begin
      pending_q <= 1'b1;
      wr_q      <= cpu_wr_i;
      sel_q     <= req_sel;
    end else if (cpu_ack_o) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cpu_req_i) wdata_q <= cpu_wdata_i;
  end

  // Port accesses wait on the packer or the response queue
  always_comb begin
    access_done = 1'b1;
    if (sel_q == SEL_CMD_PORT && wr_q) access_done = dword_done_i;
    if (sel_q == SEL_RESP_PORT && !wr_q) access_done = resp_valid_i;
  end

  assign cpu_ack_o     = pending_q && access_done;
  assign wr_ack        = cpu_ack_o && wr_q;
  assign dword_valid_o = pending_q && wr_q && (sel_q == SEL_CMD_PORT);
  assign dword_data_o  = wdata_q;
  assign resp_pop_o    = cpu_ack_o && !wr_q && (sel_q == SEL_RESP_PORT);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= '0; // Trigger off until programmed
      resp_thld_q <= '0;
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
    end else begin
      cmd_rst_q  <= 1'b0; // Self-clearing
      resp_rst_q <= 1'b0;
      if (wr_ack && sel_q == SEL_THLD) begin
        cmd_thld_q  <= clamp_thld(wdata_q[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]);
        resp_thld_q <= clamp_thld(wdata_q[`HCI_RESP_THLD_LSB +: `HCI_THLD_W]);
      end
      if (wr_ack && sel_q == SEL_RESET) begin
        cmd_rst_q  <= wdata_q[`HCI_CMD_RST_BIT];
        resp_rst_q <= wdata_q[`HCI_RESP_RST_BIT];
      end
    end
  end

  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;
  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;

  always_comb begin
    cpu_rdata_o = '0;
    if (!wr_q) begin
      unique case (sel_q)
        SEL_RESP_PORT: cpu_rdata_o = resp_data_i;
        SEL_THLD: begin
          cpu_rdata_o[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]  = cmd_thld_q;
          cpu_rdata_o[`HCI_RESP_THLD_LSB +: `HCI_THLD_W] = resp_thld_q;
        end
        SEL_RESET: begin
          cpu_rdata_o[`HCI_CMD_RST_BIT]  = cmd_rst_q;
          cpu_rdata_o[`HCI_RESP_RST_BIT] = resp_rst_q;
        end
        SEL_STATUS: begin
          cpu_rdata_o[`HCI_CMD_THLD_LSB +: $bits(cmd_cnt_i)]   = cmd_cnt_i;
          cpu_rdata_o[`HCI_RESP_THLD_LSB +: $bits(resp_cnt_i)] = resp_cnt_i;
        end
        default: ; // Command port and unmapped read 0
      endcase
    end
  end

  // Each ack answers a request that no earlier ack has closed
  a_ack_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_ack_o |-> $past(cpu_req_i) || $past(pending_q && !cpu_ack_o));

  a_cmd_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_flush_o |=> !cmd_flush_o);

  a_resp_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_flush_o |=> !resp_flush_o);

endmodule

// File: source/hci_queue.sv
/* Circular-buffer FIFO with typed payload, fill count, full/empty flags,
   ready-threshold trigger and synchronous flush */
`include "hci_cfg.svh"

module hci_queue #(
  parameter type         payload_t = hci_queue_pkg::resp_desc_t,
  parameter int unsigned Depth     = `HCI_QUEUE_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       push_valid_i,
  input  payload_t                   push_data_i,
  output logic                       push_ready_o,
  output logic                       pop_valid_o,
  output payload_t                   pop_data_o,
  input  logic                       pop_ready_i,
  input  hci_csr_pkg::thld_t         thld_i,
  output hci_queue_pkg::queue_cnt_t  cnt_o,
  output logic                       full_o,
  output logic                       empty_o,
  output logic                       thld_trig_o
);
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  // Wider than a DWORD means command descriptors, filled by the CPU
  localparam bit CpuFed = ($bits(payload_t) > `HCI_CSR_DW);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  queue_cnt_t      cnt_q;
  queue_cnt_t      free_slots;
  thld_t           level;
  logic            push_en;
  logic            pop_en;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o       = (cnt_q == queue_cnt_t'(Depth));
  assign empty_o      = (cnt_q == '0);
  assign push_ready_o = !full_o;
  assign pop_valid_o  = !empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q]; // Head entry, visible the cycle after its push
  assign cnt_o        = cnt_q;

  assign push_en = push_valid_i && push_ready_o;
  assign pop_en  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push_en) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0; // Soft reset wins over traffic
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_en) rd_ptr_q <= next_ptr(rd_ptr_q);
      unique case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ; // Both or neither, count holds
      endcase
    end
  end

  // Command side watches free slots, response side watches entries
  assign free_slots  = queue_cnt_t'(Depth) - cnt_q;
  assign level       = CpuFed ? thld_t'(free_slots) : thld_t'(cnt_q);
  assign thld_trig_o = (thld_i != '0) && (level >= thld_i); // Zero means not programmed

  // A full queue left unpopped stays full, nothing slipped in
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o && !pop_en && !flush_i |=> full_o && $stable(wr_ptr_q));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    empty_o && !push_en && !flush_i |=> empty_o && $stable(rd_ptr_q));

endmodule

// File: source/hci_queue_pkg.sv
/* Queue payload and occupancy types: command and response descriptors, entry count */
`include "hci_cfg.svh"

package hci_queue_pkg;

  // Two COMMAND_PORT DWORDs, first written lands in lo
  typedef struct packed {
    logic [`HCI_CSR_DW-1:0] hi;
    logic [`HCI_CSR_DW-1:0] lo;
  } cmd_desc_t;

  typedef logic [`HCI_CSR_DW-1:0] resp_desc_t;

  // Holds 0 up to the full depth
  typedef logic [$clog2(`HCI_QUEUE_DEPTH + 1)-1:0] queue_cnt_t;

endpackage

// File: source/hci_top.sv
/* HCI PIO queue core top: CSR block, command packer, command and response queues */
`include "hci_cfg.svh"

module hci_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // CPU request/acknowledge
  input  logic                       cpu_req_i,
  input  logic                       cpu_wr_i,
  input  hci_csr_pkg::csr_addr_t     cpu_addr_i,
  input  hci_csr_pkg::csr_data_t     cpu_wdata_i,
  output logic                       cpu_ack_o,
  output hci_csr_pkg::csr_data_t     cpu_rdata_o,

  // Controller command pop
  output logic                       hci_cmd_rvalid_o,
  input  logic                       hci_cmd_rready_i,
  output hci_queue_pkg::cmd_desc_t   hci_cmd_rdata_o,

  // Controller response push
  input  logic                       hci_resp_wvalid_i,
  output logic                       hci_resp_wready_o,
  input  hci_queue_pkg::resp_desc_t  hci_resp_wdata_i,

  output logic                       hci_cmd_full_o,
  output logic                       hci_cmd_empty_o,
  output logic                       hci_cmd_ready_thld_trig_o,
  output hci_queue_pkg::queue_cnt_t  hci_cmd_depth_o,
  output logic                       hci_resp_full_o,
  output logic                       hci_resp_empty_o,
  output logic                       hci_resp_ready_thld_trig_o,
  output hci_queue_pkg::queue_cnt_t  hci_resp_depth_o
);
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;

  logic       dword_valid;
  csr_data_t  dword_data;
  logic       dword_done;
  logic       cmd_push_valid;
  cmd_desc_t  cmd_push_data;
  logic       cmd_push_ready;
  logic       resp_valid;
  resp_desc_t resp_data;
  logic       resp_pop;
  thld_t      cmd_thld;
  thld_t      resp_thld;
  logic       cmd_flush;
  logic       resp_flush;

  hci_csr_regs u_csr_regs (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_wr_i,
    .cpu_addr_i,
    .cpu_wdata_i,
    .cpu_ack_o,
    .cpu_rdata_o,
    .dword_valid_o (dword_valid),
    .dword_data_o  (dword_data),
    .dword_done_i  (dword_done),
    .resp_valid_i  (resp_valid),
    .resp_data_i   (resp_data),
    .resp_pop_o    (resp_pop),
    .cmd_thld_o    (cmd_thld),
    .resp_thld_o   (resp_thld),
    .cmd_flush_o   (cmd_flush),
    .resp_flush_o  (resp_flush),
    .cmd_cnt_i     (hci_cmd_depth_o),
    .resp_cnt_i    (hci_resp_depth_o)
  );

  hci_cmd_packer u_cmd_packer (
    .clk_i,
    .rst_ni,
    .dword_valid_i (dword_valid),
    .dword_data_i  (dword_data),
    .dword_done_o  (dword_done),
    .push_valid_o  (cmd_push_valid),
    .push_data_o   (cmd_push_data),
    .push_ready_i  (cmd_push_ready),
    .flush_i       (cmd_flush)
  );

  hci_queue #(
    .payload_t (cmd_desc_t),
    .Depth     (`HCI_QUEUE_DEPTH)
  ) cmd_queue (
    .clk_i,
    .rst_ni,
    .flush_i      (cmd_flush),
    .push_valid_i (cmd_push_valid),
    .push_data_i  (cmd_push_data),
    .push_ready_o (cmd_push_ready),
    .pop_valid_o  (hci_cmd_rvalid_o),
    .pop_data_o   (hci_cmd_rdata_o),
    .pop_ready_i  (hci_cmd_rready_i),
    .thld_i       (cmd_thld),
    .cnt_o        (hci_cmd_depth_o),
    .full_o       (hci_cmd_full_o),
    .empty_o      (hci_cmd_empty_o),
    .thld_trig_o  (hci_cmd_ready_thld_trig_o)
  );

  hci_queue #(
    .payload_t (resp_desc_t),
    .Depth     (`HCI_QUEUE_DEPTH)
  ) resp_queue (
    .clk_i,
    .rst_ni,
    .flush_i      (resp_flush),
    .push_valid_i (hci_resp_wvalid_i),
    .push_data_i  (hci_resp_wdata_i),
    .push_ready_o (hci_resp_wready_o),
    .pop_valid_o  (resp_valid),
    .pop_data_o   (resp_data),
    .pop_ready_i  (resp_pop),
    .thld_i       (resp_thld),
    .cnt_o        (hci_resp_depth_o),
    .full_o       (hci_resp_full_o),
    .empty_o      (hci_resp_empty_o),
    .thld_trig_o  (hci_resp_ready_thld_trig_o)
  );

endmodule

// File: testbench/tb_hci.sv
/* Testbench for the HCI PIO queue core: CPU and controller drivers,
   queue reference model, concurrent and immediate checks */
`include "hci_cfg.svh"

module tb_hci;
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;

  localparam int          Depth         = `HCI_QUEUE_DEPTH;
  localparam int          TimeoutCycles = 200;
  localparam int          DrvDly        = 10; // Inputs change this long after the rising edge
  localparam logic [31:0] Seed          = 32'h845603f8;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       cpu_req_i;
  logic       cpu_wr_i;
  csr_addr_t  cpu_addr_i;
  csr_data_t  cpu_wdata_i;
  logic       cpu_ack_o;
  csr_data_t  cpu_rdata_o;
  logic       hci_cmd_rvalid_o;
  logic       hci_cmd_rready_i;
  cmd_desc_t  hci_cmd_rdata_o;
  logic       hci_resp_wvalid_i;
  logic       hci_resp_wready_o;
  resp_desc_t hci_resp_wdata_i;
  logic       hci_cmd_full_o;
  logic       hci_cmd_empty_o;
  logic       hci_cmd_ready_thld_trig_o;
  queue_cnt_t hci_cmd_depth_o;
  logic       hci_resp_full_o;
  logic       hci_resp_empty_o;
  logic       hci_resp_ready_thld_trig_o;
  queue_cnt_t hci_resp_depth_o;

  // Reference model of both queues
  cmd_desc_t  cmd_exp[$];
  resp_desc_t resp_exp[$];
  int         resp_cnt_m;
  int         cmd_thld_m;
  int         resp_thld_m;
  int         n_checks;
  int         n_errors;
  int         n_timeouts;
  bit         read_done;
  bit         write_done;
  bit         flushing; // Command queue soft reset in progress

  always #50 clk_i = ~clk_i;

  hci_top dut (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_wr_i,
    .cpu_addr_i,
    .cpu_wdata_i,
    .cpu_ack_o,
    .cpu_rdata_o,
    .hci_cmd_rvalid_o,
    .hci_cmd_rready_i,
    .hci_cmd_rdata_o,
    .hci_resp_wvalid_i,
    .hci_resp_wready_o,
    .hci_resp_wdata_i,
    .hci_cmd_full_o,
    .hci_cmd_empty_o,
    .hci_cmd_ready_thld_trig_o,
    .hci_cmd_depth_o,
    .hci_resp_full_o,
    .hci_resp_empty_o,
    .hci_resp_ready_thld_trig_o,
    .hci_resp_depth_o
  );

  a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_ack_o |=> !cpu_ack_o) else note_mismatch("cpu_ack_o longer than one cycle");

  // Response queue occupancy follows the model at every edge
  a_resp_depth: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hci_resp_depth_o == queue_cnt_t'(resp_cnt_m))
    else note_mismatch($sformatf("response depth %0d, model %0d", hci_resp_depth_o, resp_cnt_m));

  a_resp_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hci_resp_full_o == (resp_cnt_m == Depth) && hci_resp_empty_o == (resp_cnt_m == 0)
    && hci_resp_wready_o == (resp_cnt_m != Depth))
    else note_mismatch("response full, empty or wready flag differs from model");

  a_resp_trig: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hci_resp_ready_thld_trig_o == (resp_thld_m != 0 && resp_cnt_m >= resp_thld_m))
    else note_mismatch("response threshold trigger differs from model");

  a_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || flushing)
    hci_cmd_rvalid_o && !hci_cmd_rready_i |=> hci_cmd_rvalid_o && $stable(hci_cmd_rdata_o))
    else note_mismatch("command descriptor changed while waiting for ready");

  task automatic note_mismatch(input string msg);
    n_errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic expect_true(input bit ok, input string msg);
    n_checks++;
    assert (ok) else note_mismatch(msg);
  endtask

  task automatic finish_run();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    n_timeouts++;
    $display("Timeout after %0d cycles waiting for %s", TimeoutCycles, what);
    finish_run();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk_i);
    #DrvDly;
  endtask

  // One-cycle request, then wait for the acknowledge at mid-cycle
  task automatic cpu_access(input logic wr, input csr_addr_t addr, input csr_data_t wdata,
                            output csr_data_t rdata, output int lat);
    int waited;
    waited      = 0;
    cpu_req_i   = 1'b1;
    cpu_wr_i    = wr;
    cpu_addr_i  = addr;
    cpu_wdata_i = wdata;
    @(posedge clk_i);
    #DrvDly;
    cpu_req_i = 1'b0;
    @(negedge clk_i);
    while (!cpu_ack_o) begin
      waited++;
      if (waited > TimeoutCycles) timeout_abort("the CPU acknowledge");
      @(negedge clk_i);
    end
    rdata = cpu_rdata_o;
    lat   = waited + 1;
    @(posedge clk_i);
    #DrvDly;
  endtask

  task automatic reg_write(input csr_addr_t addr, input csr_data_t wdata);
    csr_data_t rdata;
    int        lat;
    cpu_access(1'b1, addr, wdata, rdata, lat);
    expect_true(lat == 1, $sformatf("write ack latency %0d at %h", lat, addr));
  endtask

  task automatic reg_read_expect(input csr_addr_t addr, input csr_data_t exp);
    csr_data_t rdata;
    int        lat;
    cpu_access(1'b0, addr, '0, rdata, lat);
    expect_true(lat == 1, $sformatf("read ack latency %0d at %h", lat, addr));
    expect_true(rdata == exp, $sformatf("read %h at %h, expected %h", rdata, addr, exp));
  endtask

  // Threshold and status registers share one field layout
  function automatic csr_data_t pack_fields(input int cmd_field, input int resp_field);
    csr_data_t w;
    w = '0;
    w[`HCI_CMD_THLD_LSB +: `HCI_THLD_W]  = thld_t'(cmd_field);
    w[`HCI_RESP_THLD_LSB +: `HCI_THLD_W] = thld_t'(resp_field);
    return w;
  endfunction

  task automatic set_thresholds(input int cmd_val, input int resp_val,
                                input int exp_cmd, input int exp_resp);
    reg_write(`HCI_ADDR_QUEUE_THLD_CTRL, pack_fields(cmd_val, resp_val));
    cmd_thld_m  = exp_cmd;
    resp_thld_m = exp_resp;
    reg_read_expect(`HCI_ADDR_QUEUE_THLD_CTRL, pack_fields(exp_cmd, exp_resp));
  endtask

  function automatic cmd_desc_t random_command();
    cmd_desc_t desc;
    desc.lo = $urandom();
    desc.hi = $urandom();
    return desc;
  endfunction

  // Packer is free here, so each DWORD is acknowledged one cycle after its request
  task automatic write_command(input cmd_desc_t desc);
    csr_data_t rdata;
    int        lat;
    cpu_access(1'b1, `HCI_ADDR_COMMAND_PORT, desc.lo, rdata, lat); // Low DWORD first
    expect_true(lat == 1, $sformatf("low DWORD ack latency %0d", lat));
    cpu_access(1'b1, `HCI_ADDR_COMMAND_PORT, desc.hi, rdata, lat);
    expect_true(lat == 1, $sformatf("high DWORD ack latency %0d", lat));
    cmd_exp.push_back(desc);
  endtask

  task automatic push_response(input resp_desc_t word);
    int waited;
    waited            = 0;
    hci_resp_wvalid_i = 1'b1;
    hci_resp_wdata_i  = word;
    @(negedge clk_i);
    while (!hci_resp_wready_o) begin
      waited++;
      if (waited > TimeoutCycles) timeout_abort("response queue ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DrvDly;
    hci_resp_wvalid_i = 1'b0;
    resp_exp.push_back(word);
    resp_cnt_m++;
  endtask

  task automatic read_response();
    csr_data_t  rdata;
    int         lat;
    resp_desc_t exp;
    cpu_access(1'b0, `HCI_ADDR_RESPONSE_PORT, '0, rdata, lat);
    if (resp_exp.size() == 0) begin
      note_mismatch("response read completed with no response pushed");
    end else begin
      exp = resp_exp.pop_front();
      resp_cnt_m--;
      expect_true(rdata == exp, $sformatf("response %h, expected %h", rdata, exp));
    end
  endtask

  task automatic pop_command();
    int        waited;
    cmd_desc_t exp;
    waited           = 0;
    hci_cmd_rready_i = 1'b1;
    @(negedge clk_i);
    while (!hci_cmd_rvalid_o) begin
      waited++;
      if (waited > TimeoutCycles) timeout_abort("a command on the controller port");
      @(negedge clk_i);
    end
    if (cmd_exp.size() == 0) begin
      note_mismatch("command popped with none written");
    end else begin
      exp = cmd_exp.pop_front();
      expect_true(hci_cmd_rdata_o == exp,
                  $sformatf("command %h, expected %h", hci_cmd_rdata_o, exp));
    end
    @(posedge clk_i);
    #DrvDly;
    hci_cmd_rready_i = 1'b0;
  endtask

  // Only called once the packer and queue have settled
  task automatic check_cmd_state(input int exp_cnt);
    bit exp_trig;
    exp_trig = (cmd_thld_m != 0) && ((Depth - exp_cnt) >= cmd_thld_m); // Free slots rule
    expect_true(hci_cmd_depth_o == queue_cnt_t'(exp_cnt),
                $sformatf("command depth %0d, expected %0d", hci_cmd_depth_o, exp_cnt));
    expect_true(hci_cmd_full_o == (exp_cnt == Depth) && hci_cmd_empty_o == (exp_cnt == 0),
                "command full or empty flag wrong");
    expect_true(hci_cmd_ready_thld_trig_o == exp_trig, "command threshold trigger wrong");
  endtask

  initial begin
    cmd_desc_t desc;
    csr_data_t rdata;
    int        lat;
    void'($urandom(Seed));
    rst_ni            = 1'b0;
    cpu_req_i         = 1'b0;
    cpu_wr_i          = 1'b0;
    cpu_addr_i        = '0;
    cpu_wdata_i       = '0;
    hci_cmd_rready_i  = 1'b0;
    hci_resp_wvalid_i = 1'b0;
    hci_resp_wdata_i  = '0;
    resp_cnt_m        = 0;
    cmd_thld_m        = 0;
    resp_thld_m       = 0;
    flushing          = 1'b0;
    repeat (10) @(posedge clk_i);
    #DrvDly;
    rst_ni = 1'b1;

    expect_true(!cpu_ack_o && !hci_cmd_rvalid_o && !hci_cmd_full_o && !hci_resp_full_o,
                "active output after reset");
    expect_true(!hci_cmd_ready_thld_trig_o && !hci_resp_ready_thld_trig_o,
                "trigger active after reset");
    check_cmd_state(0);
    reg_read_expect(12'h3FC, '0); // Unmapped address

    // Clamp at both ends, then mid values
    set_thresholds(0, 255, 1, Depth);
    set_thresholds(255, 0, Depth, 1);
    set_thresholds(3, 5, 3, 5);

    read_done = 1'b0;
    fork
      begin
        read_response();
        read_done = 1'b1;
      end
      begin
        idle(4);
        expect_true(!read_done, "response read completed on an empty queue");
        push_response($urandom());
      end
    join
    repeat (5) push_response($urandom());
    repeat (5) read_response();
    repeat (Depth) push_response($urandom()); // Trigger crosses 5 on the way
    expect_true(hci_resp_full_o && !hci_resp_wready_o, "response queue not full");
    repeat (Depth) read_response();

    // Queue full plus one descriptor held in the packer
    repeat (Depth + 1) write_command(random_command());
    idle(1);
    check_cmd_state(Depth);
    desc       = random_command();
    write_done = 1'b0;
    fork
      begin
        cpu_access(1'b1, `HCI_ADDR_COMMAND_PORT, desc.lo, rdata, lat);
        write_done = 1'b1;
      end
      begin
        idle(6);
        expect_true(!write_done, "COMMAND_PORT write acknowledged while the packer was full");
        pop_command();
      end
    join
    cpu_access(1'b1, `HCI_ADDR_COMMAND_PORT, desc.hi, rdata, lat);
    cmd_exp.push_back(desc);
    repeat (Depth + 1) pop_command();
    idle(1);
    check_cmd_state(0);

    // Soft reset of each queue leaves the other alone
    repeat (3) push_response($urandom());
    repeat (2) write_command(random_command());
    idle(1);
    reg_write(`HCI_ADDR_RESET_CONTROL, csr_data_t'(1) << `HCI_RESP_RST_BIT);
    idle(1);
    resp_exp.delete();
    resp_cnt_m = 0;
    expect_true(hci_resp_empty_o && hci_resp_depth_o == '0, "response queue not flushed");
    reg_read_expect(`HCI_ADDR_RESET_CONTROL, '0);
    reg_read_expect(`HCI_ADDR_QUEUE_STATUS, pack_fields(2, 0));
    push_response($urandom());
    flushing = 1'b1;
    reg_write(`HCI_ADDR_RESET_CONTROL, csr_data_t'(1) << `HCI_CMD_RST_BIT);
    idle(1);
    cmd_exp.delete();
    check_cmd_state(0);
    idle(1);
    flushing = 1'b0;
    reg_read_expect(`HCI_ADDR_RESET_CONTROL, '0);
    reg_read_expect(`HCI_ADDR_QUEUE_STATUS, pack_fields(0, 1));
    read_response();
    idle(2);
    finish_run();
  end

endmodule
